/* logic/dma_macros.svh */
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// bus widths of the single channel
`define DMA_ADDR_W 8
`define DMA_DATA_W 8
`define DMA_COUNT_W 16

// register offsets seen on cpu_addr while the controller is idle
`define DMA_REG_SRC 4'd0
`define DMA_REG_DST 4'd1
`define DMA_REG_CNT_LO 4'd2
`define DMA_REG_CNT_HI 4'd3
`define DMA_REG_MODE 4'd4
`define DMA_REG_MASK 4'd5
`define DMA_REG_REQ 4'd6
`define DMA_REG_STATUS 4'd7

// the word count wraps to all ones once the last transfer has stepped it
`define DMA_TC_VALUE {`DMA_COUNT_W{1'b1}}

`endif

/* logic/dma_pkg.sv */
`include "dma_macros.svh"

package dma_pkg;

  // transfer type as programmed in the low two bits of the mode register
  // encoding 3 is reserved and produces a bus cycle with no strobes
  typedef enum logic [1:0] {
    xfer_write      = 2'd0,
    xfer_read       = 2'd1,
    xfer_mem_to_mem = 2'd2
  } xfer_type_t;

  // si is idle, s0 waits for hlda, s1 to s4 make up one bus cycle
  typedef enum logic [2:0] {
    si = 3'd0,
    s0 = 3'd1,
    s1 = 3'd2,
    s2 = 3'd3,
    s3 = 3'd4,
    s4 = 3'd5
  } cycle_state_t;

  // mode register contents, bits 2 to 1 hold the transfer type and bit 0 selects a descending address
  typedef struct packed {
    xfer_type_t xfer;
    logic       decrement;
  } mode_t;

  // everything the cycle timer and the datapath need from the registers
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0]  src_addr;
    logic [`DMA_ADDR_W-1:0]  dst_addr;
    logic [`DMA_COUNT_W-1:0] count;
    mode_t                   mode;
    logic                    mask;
    logic                    sw_req;
    // the transfer about to run is the last one
    logic                    terminal_next;
  } channel_t;

  // state and phase describe the current cycle, as do load_buf and step
  // the pin enables describe the cycle that opens at the next edge
  typedef struct packed {
    cycle_state_t state;
    logic         phase;
    logic         aen;
    logic         drive_addr;
    logic         use_dst;
    logic         ior;
    logic         iow;
    logic         memr;
    logic         memw;
    logic         load_buf;
    logic         drive_buf;
    logic         eop;
    logic         step;
  } cycle_ctrl_t;

endpackage

/* logic/dma_registers.sv */
`timescale 1ns/100ps
`include "dma_macros.svh"

module dma_registers (
  input  logic                   dma_if,
  input  logic                   rst,
  input  logic                   cs_n,
  input  logic                   cpu_ior_n,
  input  logic                   cpu_iow_n,
  input  logic [3:0]             cpu_addr,
  input  logic [`DMA_DATA_W-1:0] db_sample,
  input  logic                   hlda,
  input  logic                   step,
  input  logic                   eop,
  output dma_pkg::channel_t      channel,
  output logic [`DMA_DATA_W-1:0] reg_rdata,
  output logic                   reg_rd
);

  logic [`DMA_ADDR_W-1:0]  src_addr;
  logic [`DMA_ADDR_W-1:0]  dst_addr;
  logic [`DMA_COUNT_W-1:0] count;
  logic [`DMA_COUNT_W-1:0] count_next;
  dma_pkg::mode_t          mode;
  logic                    mask;
  logic                    sw_req;
  logic                    tc;
  logic                    reg_wr;

  // the cpu owns the register port only while the bus is not granted
  assign reg_wr = !cs_n && !cpu_iow_n && !hlda;
  assign reg_rd = !cs_n && !cpu_ior_n && !hlda;

  // count after the transfer in flight, it reaches all ones after the last one
  assign count_next = count - 1'b1;

  // addresses and count are loaded by the cpu and walked by the cycle timer
  // the cpu cannot write while hlda is high, so the two never collide
  always_ff @(posedge dma_if) begin
    if (reg_wr) begin
      case (cpu_addr)
        `DMA_REG_SRC: src_addr <= db_sample;
        `DMA_REG_DST: dst_addr <= db_sample;
        `DMA_REG_CNT_LO: count[`DMA_DATA_W-1:0] <= db_sample;
        `DMA_REG_CNT_HI: count[`DMA_COUNT_W-1:`DMA_DATA_W] <= db_sample;
        default: ;
      endcase
    end else if (step) begin
      count <= count_next;
      // the memory address moves on every transfer
      if (mode.decrement) begin
        src_addr <= src_addr - 1'b1;
      end else begin
        src_addr <= src_addr + 1'b1;
      end
      // the destination only moves when memory to memory uses it
      if (mode.xfer == dma_pkg::xfer_mem_to_mem) begin
        if (mode.decrement) begin
          dst_addr <= dst_addr - 1'b1;
        end else begin
          dst_addr <= dst_addr + 1'b1;
        end
      end
    end
  end

  // mode, mask, request and the tc status flag
  always_ff @(posedge dma_if) begin
    if (rst) begin
      mode   <= '0;
      mask   <= 1'b1;
      sw_req <= 1'b0;
      tc     <= 1'b0;
    end else begin
      if (reg_wr) begin
        case (cpu_addr)
          `DMA_REG_MODE: mode <= dma_pkg::mode_t'(db_sample[2:0]);
          `DMA_REG_MASK: mask <= db_sample[0];
          `DMA_REG_REQ: sw_req <= db_sample[0];
          default: ;
        endcase
      end
      // terminal count parks the channel until the cpu unmasks it again
      if (eop) begin
        tc     <= 1'b1;
        mask   <= 1'b1;
        sw_req <= 1'b0;
      end else if (reg_rd && cpu_addr == `DMA_REG_STATUS) begin
        // a status read acknowledges tc
        tc <= 1'b0;
      end
    end
  end

  always_comb begin
    channel.src_addr      = src_addr;
    channel.dst_addr      = dst_addr;
    channel.count         = count;
    channel.mode          = mode;
    channel.mask          = mask;
    channel.sw_req        = sw_req;
    channel.terminal_next = (count_next == `DMA_TC_VALUE);
  end

  // readback mux, status keeps the 8237 layout of tc in bit 0, request in bit 4
  always_comb begin
    reg_rdata = '0;
    case (cpu_addr)
      `DMA_REG_SRC: reg_rdata = src_addr;
      `DMA_REG_DST: reg_rdata = dst_addr;
      `DMA_REG_CNT_LO: reg_rdata = count[`DMA_DATA_W-1:0];
      `DMA_REG_CNT_HI: reg_rdata = count[`DMA_COUNT_W-1:`DMA_DATA_W];
      `DMA_REG_MODE: reg_rdata[2:0] = mode;
      `DMA_REG_MASK: reg_rdata[0] = mask;
      `DMA_REG_REQ: reg_rdata[0] = sw_req;
      `DMA_REG_STATUS: begin
        reg_rdata[0] = tc;
        reg_rdata[4] = sw_req;
      end
      default: reg_rdata = '0;
    endcase
  end

  // the cycle timer may only walk the channel while it owns the bus
  step_needs_grant: assert property (@(posedge dma_if) disable iff (rst) step |-> hlda)
    else $error("step issued while hlda is low");

endmodule

/* logic/dma_timing.sv */
`timescale 1ns/100ps
`include "dma_macros.svh"

module dma_timing (
  input  logic                 dma_if,
  input  logic                 rst,
  input  logic                 dreq,
  input  logic                 hlda,
  input  dma_pkg::channel_t    channel,
  output logic                 hrq,
  output logic                 dack,
  output dma_pkg::cycle_ctrl_t ctrl
);

  dma_pkg::cycle_state_t state;
  dma_pkg::cycle_state_t state_nx;
  logic                  phase;
  logic                  phase_nx;
  logic                  is_write;
  logic                  is_read;
  logic                  is_m2m;
  logic                  req;
  logic                  busy_nx;
  logic                  window_nx;

  assign is_write = (channel.mode.xfer == dma_pkg::xfer_write);
  assign is_read  = (channel.mode.xfer == dma_pkg::xfer_read);
  assign is_m2m   = (channel.mode.xfer == dma_pkg::xfer_mem_to_mem);

  // memory to memory is started by software, the i/o types by the device
  assign req = !channel.mask && (is_m2m ? channel.sw_req : dreq);

  // one transfer per request, so every cycle goes back through si
  // memory to memory runs s1 to s4 twice, phase selects read or write half
  always_comb begin
    state_nx = state;
    phase_nx = phase;
    case (state)
      dma_pkg::si: begin
        if (req) begin
          state_nx = dma_pkg::s0;
          phase_nx = 1'b0;
        end
      end
      dma_pkg::s0: begin
        // hold here for as long as the cpu keeps the bus
        if (hlda) begin
          state_nx = dma_pkg::s1;
        end
      end
      dma_pkg::s1: state_nx = dma_pkg::s2;
      dma_pkg::s2: state_nx = dma_pkg::s3;
      dma_pkg::s3: state_nx = dma_pkg::s4;
      dma_pkg::s4: begin
        if (is_m2m && !phase) begin
          state_nx = dma_pkg::s1;
          phase_nx = 1'b1;
        end else begin
          state_nx = dma_pkg::si;
          phase_nx = 1'b0;
        end
      end
      default: begin
        state_nx = dma_pkg::si;
        phase_nx = 1'b0;
      end
    endcase
  end

  always_ff @(posedge dma_if) begin
    if (rst) begin
      state <= dma_pkg::si;
      phase <= 1'b0;
      hrq   <= 1'b0;
      dack  <= 1'b0;
    end else begin
      state <= state_nx;
      phase <= phase_nx;
      // hrq stays up from s0 until the cycle is back in si
      hrq   <= (state_nx != dma_pkg::si);
      // memory to memory has no device to acknowledge
      dack  <= !is_m2m && (state_nx inside {dma_pkg::s2, dma_pkg::s3, dma_pkg::s4});
    end
  end

  // the datapath registers the pin enables, so they are decoded one state ahead
  assign busy_nx   = state_nx inside {dma_pkg::s1, dma_pkg::s2, dma_pkg::s3, dma_pkg::s4};
  assign window_nx = state_nx inside {dma_pkg::s2, dma_pkg::s3};

  always_comb begin
    ctrl            = '0;
    ctrl.state      = state;
    ctrl.phase      = phase;
    ctrl.aen        = busy_nx;
    ctrl.drive_addr = busy_nx;
    ctrl.use_dst    = is_m2m && phase_nx;
    // io to memory reads the device and writes memory
    ctrl.ior        = window_nx && is_write;
    ctrl.memw       = window_nx && (is_write || (is_m2m && phase_nx));
    // memory to io reads memory and writes the device
    ctrl.memr       = window_nx && (is_read || (is_m2m && !phase_nx));
    ctrl.iow        = window_nx && is_read;
    ctrl.drive_buf  = window_nx && is_m2m && phase_nx;
    // eop marks the s4 that closes the last transfer
    ctrl.eop        = (state_nx == dma_pkg::s4) && channel.terminal_next &&
                      (!is_m2m || phase_nx);
    // the read half ends with the memory byte captured into the buffer
    ctrl.load_buf   = (state == dma_pkg::s3) && is_m2m && !phase;
    ctrl.step       = (state == dma_pkg::s4) && (!is_m2m || phase);
  end

  no_mem_contention: assert property (@(posedge dma_if) disable iff (rst)
    !(ctrl.memr && ctrl.memw))
    else $error("memr and memw requested together");

  no_io_contention: assert property (@(posedge dma_if) disable iff (rst)
    !(ctrl.ior && ctrl.iow))
    else $error("ior and iow requested together");

  // the device may only be acknowledged while the cpu has released the bus
  dack_under_grant: assert property (@(posedge dma_if) disable iff (rst) dack |-> hlda)
    else $error("dack high without hlda");

endmodule

/* logic/dma_datapath.sv */
`timescale 1ns/100ps
`include "dma_macros.svh"

module dma_datapath (
  input  logic                       dma_if,
  input  logic                       rst,
  input  dma_pkg::cycle_ctrl_t       ctrl,
  input  dma_pkg::channel_t          channel,
  input  logic [`DMA_DATA_W-1:0]     reg_rdata,
  input  logic                       reg_rd,
  input  logic [`DMA_DATA_W-1:0]     db_sample,
  output logic [`DMA_DATA_W-1:0]     db_drive,
  output logic                       db_drive_en,
  output logic [`DMA_ADDR_W/2-1:0]   addr_u,
  output logic [`DMA_ADDR_W/2-1:0]   addr_l,
  output logic                       addr_en,
  output logic                       ior_n,
  output logic                       iow_n,
  output logic                       memr_n,
  output logic                       memw_n,
  output logic                       eop_n,
  output logic                       aen,
  output logic                       adstb
);

  logic [`DMA_ADDR_W-1:0] addr_q;
  logic [`DMA_DATA_W-1:0] rd_buf;
  logic                   buf_drive;

  // pin register stage, every strobe changes on the edge that opens its state
  always_ff @(posedge dma_if) begin
    if (rst) begin
      ior_n     <= 1'b1;
      iow_n     <= 1'b1;
      memr_n    <= 1'b1;
      memw_n    <= 1'b1;
      eop_n     <= 1'b1;
      aen       <= 1'b0;
      adstb     <= 1'b0;
      addr_en   <= 1'b0;
      buf_drive <= 1'b0;
    end else begin
      ior_n     <= !ctrl.ior;
      iow_n     <= !ctrl.iow;
      memr_n    <= !ctrl.memr;
      memw_n    <= !ctrl.memw;
      eop_n     <= !ctrl.eop;
      aen       <= ctrl.aen;
      addr_en   <= ctrl.drive_addr;
      buf_drive <= ctrl.drive_buf;
      // address strobe for one cycle when aen first rises, that is in s1
      adstb     <= ctrl.aen && !aen;
    end
  end

  // the address is captured while the registers still hold the current transfer
  // the step at the end of s4 then cannot disturb the pins
  always_ff @(posedge dma_if) begin
    if (ctrl.drive_addr) begin
      addr_q <= ctrl.use_dst ? channel.dst_addr : channel.src_addr;
    end
  end

  // temporary buffer, filled from memory at the end of s3 of the read half
  always_ff @(posedge dma_if) begin
    if (ctrl.load_buf) begin
      rd_buf <= db_sample;
    end
  end

  assign addr_u = addr_q[`DMA_ADDR_W-1:`DMA_ADDR_W/2];
  assign addr_l = addr_q[`DMA_ADDR_W/2-1:0];

  // the data bus carries the buffer in the write half, otherwise cpu readback
  assign db_drive    = buf_drive ? rd_buf : reg_rdata;
  assign db_drive_en = buf_drive || reg_rd;

  // a register read needs hlda low and the buffer needs it high, so both can't drive
  no_bus_fight: assert property (@(posedge dma_if) disable iff (rst)
    !(buf_drive && reg_rd))
    else $error("buffer and register readback both on the data bus");

endmodule

/* logic/dma_top.sv */
`timescale 1ns/100ps
`include "dma_macros.svh"

module dma_top (
  input  logic                     dma_if,
  input  logic                     rst,
  input  logic                     cs_n,
  input  logic                     cpu_ior_n,
  input  logic                     cpu_iow_n,
  input  logic [3:0]               cpu_addr,
  input  logic [`DMA_DATA_W-1:0]   db_sample,
  output logic [`DMA_DATA_W-1:0]   db_drive,
  output logic                     db_drive_en,
  output logic [`DMA_ADDR_W/2-1:0] addr_u,
  output logic [`DMA_ADDR_W/2-1:0] addr_l,
  output logic                     addr_en,
  output logic                     ior_n,
  output logic                     iow_n,
  output logic                     memr_n,
  output logic                     memw_n,
  output logic                     eop_n,
  output logic                     aen,
  output logic                     adstb,
  input  logic                     dreq,
  output logic                     hrq,
  input  logic                     hlda,
  output logic                     dack
);

  dma_pkg::channel_t      channel;
  dma_pkg::cycle_ctrl_t   ctrl;
  logic [`DMA_DATA_W-1:0] reg_rdata;
  logic                   reg_rd;

  // programming registers, walked by step and stopped by eop
  dma_registers u_registers (
    .dma_if    (dma_if),
    .rst       (rst),
    .cs_n      (cs_n),
    .cpu_ior_n (cpu_ior_n),
    .cpu_iow_n (cpu_iow_n),
    .cpu_addr  (cpu_addr),
    .db_sample (db_sample),
    .hlda      (hlda),
    .step      (ctrl.step),
    .eop       (ctrl.eop),
    .channel   (channel),
    .reg_rdata (reg_rdata),
    .reg_rd    (reg_rd)
  );

  dma_timing u_timing (
    .dma_if  (dma_if),
    .rst     (rst),
    .dreq    (dreq),
    .hlda    (hlda),
    .channel (channel),
    .hrq     (hrq),
    .dack    (dack),
    .ctrl    (ctrl)
  );

  dma_datapath u_datapath (
    .dma_if      (dma_if),
    .rst         (rst),
    .ctrl        (ctrl),
    .channel     (channel),
    .reg_rdata   (reg_rdata),
    .reg_rd      (reg_rd),
    .db_sample   (db_sample),
    .db_drive    (db_drive),
    .db_drive_en (db_drive_en),
    .addr_u      (addr_u),
    .addr_l      (addr_l),
    .addr_en     (addr_en),
    .ior_n       (ior_n),
    .iow_n       (iow_n),
    .memr_n      (memr_n),
    .memw_n      (memw_n),
    .eop_n       (eop_n),
    .aen         (aen),
    .adstb       (adstb)
  );

endmodule

/* testbench/dma_clock_gen.sv */
`timescale 1ns/100ps

module dma_clock_gen (
  output logic dma_if,
  output logic rst
);

  // free running clock with a 100 ns period
  initial begin
    dma_if = 1'b0;
    forever #50 dma_if = ~dma_if;
  end

  // reset covers the first five rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge dma_if);
    rst <= 1'b0;
  end

endmodule

/* testbench/dma_tb.sv */
`timescale 1ns/100ps
`include "dma_macros.svh"

module dma_tb;

  // sum of the per test cycle budgets and a margin, used by the watchdog
  localparam int budget_cycles = 80 + 100 + 120 + 160 + 100 + 80 + 100;
  localparam string pin_names = "aen adstb dack eop_n ior_n iow_n memr_n memw_n";
  // active strobes of a bus cycle, ordered as {ior, iow, memr, memw}
  localparam logic [3:0] strobe_write = 4'b1001;
  localparam logic [3:0] strobe_read = 4'b0110;
  localparam logic [3:0] strobe_copy_rd = 4'b0010;
  localparam logic [3:0] strobe_copy_wr = 4'b0001;

  logic dma_if;
  logic rst;
  logic cs_n, cpu_ior_n, cpu_iow_n;
  logic [3:0] cpu_addr;
  logic [`DMA_DATA_W-1:0] cpu_data;
  logic [`DMA_DATA_W-1:0] db_sample, db_drive;
  logic db_drive_en;
  logic [`DMA_ADDR_W/2-1:0] addr_u, addr_l;
  logic addr_en, ior_n, iow_n, memr_n, memw_n, eop_n, aen, adstb;
  logic dreq, hrq, hlda, dack;
  // when low the host model holds off the grant
  logic grant_en;

  // memory, device source bytes and the log of device writes
  logic [`DMA_DATA_W-1:0] mem [0:255];
  logic [`DMA_DATA_W-1:0] dev_bytes [0:15];
  logic [`DMA_DATA_W-1:0] io_log [0:15];
  logic [3:0] dev_idx, io_cnt;
  logic memw_q, iow_q, ior_q;
  logic [`DMA_ADDR_W-1:0] bus_addr;
  logic [`DMA_DATA_W-1:0] bus_data;
  logic [7:0] lfsr;
  int checks;
  int errors;

  dma_clock_gen clock_gen (.dma_if(dma_if), .rst(rst));

  dma_top DUT (.*);

  // host model, hlda follows hrq one cycle late unless grant_en holds it off
  always @(posedge dma_if) begin
    if (rst) begin
      hlda <= 1'b0;
    end else begin
      hlda <= hrq && grant_en;
    end
  end

  // the data bus carries memory on memr, the device on ior, otherwise the cpu
  assign bus_addr = {addr_u, addr_l};
  assign db_sample = !memr_n ? mem[bus_addr] : (!ior_n ? dev_bytes[dev_idx] : cpu_data);
  assign bus_data = db_drive_en ? db_drive : db_sample;

  // writes land on the first cycle of their strobe, a device read ends on ior rising
  always @(posedge dma_if) begin
    memw_q <= memw_n;
    iow_q <= iow_n;
    ior_q <= ior_n;
    if (rst) begin
      dev_idx <= '0;
      io_cnt <= '0;
    end else begin
      if (!memw_n && memw_q) mem[bus_addr] <= bus_data;
      if (!iow_n && iow_q) begin
        io_log[io_cnt] <= bus_data;
        io_cnt <= io_cnt + 1'b1;
      end
      if (ior_n && !ior_q) dev_idx <= dev_idx + 1'b1;
    end
  end

  // maximal length sequence from taps 8, 6, 5 and 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // one lfsr step for every bit of the byte
  task automatic random_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  // memory preload, every address bit shows up in the byte
  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return {a[3:0], a[7:4]} ^ 8'h96;
  endfunction

  // mode register layout is {transfer type, decrement} in the low three bits
  function automatic logic [7:0] mode_byte(input logic [1:0] xfer, input logic dec);
    return {5'b0, xfer, dec};
  endfunction

  function automatic logic [7:0] pin_view();
    return {aen, adstb, dack, eop_n, ior_n, iow_n, memr_n, memw_n};
  endfunction

  task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic cpu_write(input logic [3:0] a, input logic [7:0] d);
    @(posedge dma_if);
    cs_n <= 1'b0;
    cpu_iow_n <= 1'b0;
    cpu_addr <= a;
    cpu_data <= d;
    @(posedge dma_if);
    cs_n <= 1'b1;
    cpu_iow_n <= 1'b1;
  endtask

  // readback is on the data bus in the same cycle as the read strobe
  task automatic read_expect(input logic [3:0] a, input logic [7:0] exp, input string name);
    @(posedge dma_if);
    cs_n <= 1'b0;
    cpu_ior_n <= 1'b0;
    cpu_addr <= a;
    @(negedge dma_if);
    compare("db_drive_en", {7'b0, db_drive_en}, 8'h01);
    compare(name, db_drive, exp);
    @(posedge dma_if);
    cs_n <= 1'b1;
    cpu_ior_n <= 1'b1;
  endtask

  task automatic program_channel(input logic [7:0] src, input logic [7:0] dst,
                                 input logic [15:0] cnt, input logic [7:0] mode);
    cpu_write(`DMA_REG_SRC, src);
    cpu_write(`DMA_REG_DST, dst);
    cpu_write(`DMA_REG_CNT_LO, cnt[7:0]);
    cpu_write(`DMA_REG_CNT_HI, cnt[15:8]);
    cpu_write(`DMA_REG_MODE, mode);
    cpu_write(`DMA_REG_MASK, 8'h00);
  endtask

  // follows one s1 to s4 pass, with first set it waits for adstb to mark s1
  task automatic check_bus_cycle(input logic [3:0] low, input logic dack_exp,
                                 input logic eop_exp, input logic first,
                                 input logic [7:0] addr_exp, output int waited);
    waited = 0;
    @(negedge dma_if);
    while (first && !adstb && waited < 40) begin
      @(negedge dma_if);
      waited++;
    end
    if (first && !adstb) begin
      errors++;
      $display("no address strobe within 40 cycles at %0t", $time);
    end
    // s1 puts the address out with every strobe still high
    compare(pin_names, pin_view(), {1'b1, first, 2'b01, 4'hF});
    compare("addr_u addr_l", {addr_u, addr_l}, addr_exp);
    compare("addr_en", {7'b0, addr_en}, 8'h01);
    repeat (2) begin
      @(negedge dma_if);
      compare(pin_names, pin_view(), {2'b10, dack_exp, 1'b1, ~low});
    end
    // s4 releases the strobes, eop_n only drops on the last transfer
    @(negedge dma_if);
    compare(pin_names, pin_view(), {2'b10, dack_exp, !eop_exp, 4'hF});
  endtask

  task automatic wait_idle();
    int k;
    k = 0;
    @(negedge dma_if);
    while ((hrq || hlda) && k < 20) begin
      @(negedge dma_if);
      k++;
    end
    if (hrq || hlda) begin
      errors++;
      $display("controller did not return to idle at %0t", $time);
    end
  endtask

  task automatic test_reset_and_regs();
    compare("hrq aen adstb dack db_drive_en addr_en",
            {2'b0, hrq, aen, adstb, dack, db_drive_en, addr_en}, 8'h00);
    compare("ior_n iow_n memr_n memw_n eop_n", {3'b0, ior_n, iow_n, memr_n, memw_n, eop_n}, 8'h1F);
    read_expect(`DMA_REG_MASK, 8'h01, "mask after reset");
    cpu_write(`DMA_REG_SRC, 8'h5A);
    cpu_write(`DMA_REG_DST, 8'hC3);
    cpu_write(`DMA_REG_CNT_LO, 8'h34);
    cpu_write(`DMA_REG_CNT_HI, 8'h12);
    cpu_write(`DMA_REG_MODE, 8'h03);
    read_expect(`DMA_REG_SRC, 8'h5A, "source address");
    read_expect(`DMA_REG_DST, 8'hC3, "destination address");
    read_expect(`DMA_REG_CNT_LO, 8'h34, "count low");
    read_expect(`DMA_REG_CNT_HI, 8'h12, "count high");
    read_expect(`DMA_REG_MODE, 8'h03, "mode");
  endtask

  // count 2 moves three device bytes to ascending memory
  task automatic test_io_to_mem();
    logic [3:0] base;
    logic [7:0] b;
    int waited;
    base = dev_idx;
    for (int i = 0; i < 3; i++) begin
      random_byte(b);
      dev_bytes[4'(base + i)] = b;
    end
    program_channel(8'h30, 8'h00, 16'd2, mode_byte(dma_pkg::xfer_write, 1'b0));
    @(posedge dma_if);
    dreq <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      check_bus_cycle(strobe_write, 1'b1, i == 2, 1'b1, 8'(8'h30 + i), waited);
    end
    @(posedge dma_if);
    dreq <= 1'b0;
    wait_idle();
    for (int i = 0; i < 3; i++) begin
      compare("memory byte", mem[8'(8'h30 + i)], dev_bytes[4'(base + i)]);
    end
  endtask

  // decrement walks the memory address down from 9f
  task automatic test_mem_to_io();
    logic [3:0] base;
    int waited;
    base = io_cnt;
    program_channel(8'h9F, 8'h00, 16'd3, mode_byte(dma_pkg::xfer_read, 1'b1));
    @(posedge dma_if);
    dreq <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      check_bus_cycle(strobe_read, 1'b1, i == 3, 1'b1, 8'(8'h9F - i), waited);
    end
    @(posedge dma_if);
    dreq <= 1'b0;
    wait_idle();
    for (int i = 0; i < 4; i++) begin
      compare("device byte", io_log[4'(base + i)], fill_byte(8'(8'h9F - i)));
    end
  endtask

  // each byte takes a read half from 40 up and a write half to 80 up
  task automatic test_mem_to_mem();
    logic [7:0] src_data [0:7];
    logic [7:0] b;
    int waited;
    for (int i = 0; i < 5; i++) begin
      random_byte(b);
      src_data[3'(i)] = b;
      mem[8'(8'h40 + i)] = b;
    end
    program_channel(8'h40, 8'h80, 16'd4, mode_byte(dma_pkg::xfer_mem_to_mem, 1'b0));
    cpu_write(`DMA_REG_REQ, 8'h01);
    for (int i = 0; i < 5; i++) begin
      check_bus_cycle(strobe_copy_rd, 1'b0, 1'b0, 1'b1, 8'(8'h40 + i), waited);
      check_bus_cycle(strobe_copy_wr, 1'b0, i == 4, 1'b0, 8'(8'h80 + i), waited);
    end
    wait_idle();
    for (int i = 0; i < 5; i++) begin
      compare("copied byte", mem[8'(8'h80 + i)], src_data[3'(i)]);
    end
  endtask

  task automatic test_terminal_count();
    logic [7:0] b;
    int waited;
    // tc is still set from the previous transfer, this read acknowledges it
    read_expect(`DMA_REG_STATUS, 8'h01, "status before test");
    random_byte(b);
    dev_bytes[dev_idx] = b;
    program_channel(8'h10, 8'h00, 16'd0, mode_byte(dma_pkg::xfer_write, 1'b0));
    @(posedge dma_if);
    dreq <= 1'b1;
    check_bus_cycle(strobe_write, 1'b1, 1'b1, 1'b1, 8'h10, waited);
    // the channel is masked again, so a held dreq gets no further cycles
    repeat (12) begin
      @(negedge dma_if);
      compare("hrq", {7'b0, hrq}, 8'h00);
    end
    read_expect(`DMA_REG_STATUS, 8'h01, "status at terminal count");
    read_expect(`DMA_REG_STATUS, 8'h00, "status after read");
    read_expect(`DMA_REG_MASK, 8'h01, "mask at terminal count");
    @(posedge dma_if);
    dreq <= 1'b0;
    compare("memory byte", mem[8'h10], b);
  endtask

  task automatic test_hold_off();
    logic [7:0] b;
    int waited;
    int k;
    random_byte(b);
    dev_bytes[dev_idx] = b;
    @(posedge dma_if);
    grant_en <= 1'b0;
    program_channel(8'h20, 8'h00, 16'd0, mode_byte(dma_pkg::xfer_write, 1'b0));
    @(posedge dma_if);
    dreq <= 1'b1;
    k = 0;
    @(negedge dma_if);
    while (!hrq && k < 10) begin
      @(negedge dma_if);
      k++;
    end
    // s0 with no grant keeps every pin idle
    repeat (6) begin
      @(negedge dma_if);
      compare("hrq", {7'b0, hrq}, 8'h01);
      compare(pin_names, pin_view(), 8'h1F);
    end
    @(posedge dma_if);
    grant_en <= 1'b1;
    k = 0;
    @(negedge dma_if);
    while (!hlda && k < 10) begin
      @(negedge dma_if);
      k++;
    end
    check_bus_cycle(strobe_write, 1'b1, 1'b1, 1'b1, 8'h20, waited);
    compare("cycles from hlda to s1", 8'(waited), 8'h00);
    @(posedge dma_if);
    dreq <= 1'b0;
    wait_idle();
    compare("memory byte", mem[8'h20], b);
  endtask

  initial begin
    cs_n = 1'b1;
    cpu_ior_n = 1'b1;
    cpu_iow_n = 1'b1;
    cpu_addr = '0;
    cpu_data = '0;
    dreq = 1'b0;
    hlda = 1'b0;
    grant_en = 1'b1;
    lfsr = 8'd70;
    checks = 0;
    errors = 0;
    for (int a = 0; a < 256; a++) begin
      mem[a] = fill_byte(8'(a));
    end
    wait (rst === 1'b0);
    @(negedge dma_if);
    test_reset_and_regs();
    test_io_to_mem();
    test_mem_to_io();
    test_mem_to_mem();
    test_terminal_count();
    test_hold_off();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(budget_cycles * 100);
    $display("watchdog expired after %0d cycles before the tests finished", budget_cycles);
    $display("checks %0d errors %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/dma_pkg.sv
logic/dma_registers.sv
logic/dma_timing.sv
logic/dma_datapath.sv
logic/dma_top.sv
testbench/dma_clock_gen.sv
testbench/dma_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --assert --timescale 1ns/100ps --top-module dma_tb -f vlog.f -o dma_sim \
  || exit 1
out=$(./obj_dir/dma_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && echo PASS || { echo FAIL; exit 1; }
